/* isect_pkg.sv */
// fixed-point and identifier types shared by the intersection-decision RTL and its testbench
package isect_pkg;

  // signed Q16.16 fixed point
  localparam int FRAC_BITS = 16;
  localparam int FIX_W = 32;

  // identifier widths
  localparam int TRI_ID_W = 16;
  localparam int RAY_ID_W = 8;

  // distances, coordinates and direction components
  typedef logic signed [FIX_W-1:0] fix_t;

  // triangle identifier reported with a hit
  typedef logic [TRI_ID_W-1:0] tri_id_t;

  // ray tag, travels with each ray so reports can be matched
  typedef logic [RAY_ID_W-1:0] ray_id_t;

endpackage

/* t_comp.sv */
// picks the nearer valid hit distance and range-tests it, feeding p_calc and hit_merge
`timescale 1ns/1ns

module t_comp (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  isect_pkg::ray_id_t ray_id,
  input  isect_pkg::fix_t    t0,
  input  isect_pkg::fix_t    t1,
  input  isect_pkg::fix_t    t_min,
  input  isect_pkg::fix_t    t_max,
  input  logic               tri1_valid,
  input  isect_pkg::tri_id_t tri0_id,
  input  isect_pkg::tri_id_t tri1_id,
  output logic               sel_valid,
  output isect_pkg::fix_t    sel_t,
  output isect_pkg::tri_id_t sel_tri_id,
  output isect_pkg::ray_id_t sel_ray_id,
  output logic               rt_valid,
  output logic               rt_hit,
  output isect_pkg::fix_t    rt_t,
  output isect_pkg::tri_id_t rt_tri_id,
  output isect_pkg::ray_id_t rt_ray_id
);

  // ray as accepted
  logic               in_valid_q;
  isect_pkg::ray_id_t ray_id_q;
  isect_pkg::fix_t    t0_q;
  isect_pkg::fix_t    t1_q;
  isect_pkg::fix_t    t_min_q;
  isect_pkg::fix_t    t_max_q;
  logic               tri1_valid_q;
  isect_pkg::tri_id_t tri0_id_q;
  isect_pkg::tri_id_t tri1_id_q;

  // interval bounds carried next to the selection
  isect_pkg::fix_t    t_min_s;
  isect_pkg::fix_t    t_max_s;

  // tri0 is always valid, so only tri1 needs qualifying
  logic t_sel;

  // ties keep triangle 0
  assign t_sel = tri1_valid_q && (t1_q < t0_q);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_valid_q   <= 1'b0;
      ray_id_q     <= '0;
      t0_q         <= '0;
      t1_q         <= '0;
      t_min_q      <= '0;
      t_max_q      <= '0;
      tri1_valid_q <= 1'b0;
      tri0_id_q    <= '0;
      tri1_id_q    <= '0;
    end else begin
      in_valid_q <= in_valid;
      if (in_valid) begin
        ray_id_q     <= ray_id;
        t0_q         <= t0;
        t1_q         <= t1;
        t_min_q      <= t_min;
        t_max_q      <= t_max;
        tri1_valid_q <= tri1_valid;
        tri0_id_q    <= tri0_id;
        tri1_id_q    <= tri1_id;
      end
    end
  end

  // selection step
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel_valid  <= 1'b0;
      sel_t      <= '0;
      sel_tri_id <= '0;
      sel_ray_id <= '0;
      t_min_s    <= '0;
      t_max_s    <= '0;
    end else begin
      sel_valid  <= in_valid_q;
      sel_t      <= t_sel ? t1_q : t0_q;
      sel_tri_id <= t_sel ? tri1_id_q : tri0_id_q;
      sel_ray_id <= ray_id_q;
      t_min_s    <= t_min_q;
      t_max_s    <= t_max_q;
    end
  end

  // range test, open interval on both ends
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rt_valid  <= 1'b0;
      rt_hit    <= 1'b0;
      rt_t      <= '0;
      rt_tri_id <= '0;
      rt_ray_id <= '0;
    end else begin
      rt_valid  <= sel_valid;
      rt_hit    <= (t_min_s < sel_t) && (sel_t < t_max_s);
      rt_t      <= sel_t;
      rt_tri_id <= sel_tri_id;
      rt_ray_id <= sel_ray_id;
    end
  end

endmodule

/* p_calc.sv */
// computes the intersection point origin + t*dir for every ray, in step with t_comp
`timescale 1ns/1ns

module p_calc (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            in_valid,
  input  isect_pkg::fix_t origin_x,
  input  isect_pkg::fix_t origin_y,
  input  isect_pkg::fix_t origin_z,
  input  isect_pkg::fix_t dir_x,
  input  isect_pkg::fix_t dir_y,
  input  isect_pkg::fix_t dir_z,
  input  logic            sel_valid,
  input  isect_pkg::fix_t sel_t,
  output logic            p_valid,
  output isect_pkg::fix_t p_x,
  output isect_pkg::fix_t p_y,
  output isect_pkg::fix_t p_z
);

  // full signed product, then drop the extra fraction bits
  function automatic isect_pkg::fix_t scale(input isect_pkg::fix_t t, input isect_pkg::fix_t d);
    logic signed [2*isect_pkg::FIX_W-1:0] full;
    full = t * d;
    return full[isect_pkg::FRAC_BITS +: isect_pkg::FIX_W];
  endfunction

  // accepted ray
  logic            v_a;
  isect_pkg::fix_t org_a [3];
  isect_pkg::fix_t dir_a [3];

  // lined up with sel_t
  isect_pkg::fix_t org_b [3];
  isect_pkg::fix_t dir_b [3];

  // products and the origins that go with them
  logic            v_c;
  isect_pkg::fix_t prod_c [3];
  isect_pkg::fix_t org_c [3];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v_a <= 1'b0;
      v_c <= 1'b0;
      for (int i = 0; i < 3; i++) begin
        org_a[i]  <= '0;
        dir_a[i]  <= '0;
        org_b[i]  <= '0;
        dir_b[i]  <= '0;
        prod_c[i] <= '0;
        org_c[i]  <= '0;
      end
    end else begin
      v_a <= in_valid;
      if (in_valid) begin
        org_a <= '{origin_x, origin_y, origin_z};
        dir_a <= '{dir_x, dir_y, dir_z};
      end
      if (v_a) begin
        org_b <= org_a;
        dir_b <= dir_a;
      end
      // a point is formed even for rays that will miss
      v_c <= sel_valid;
      for (int i = 0; i < 3; i++) begin
        prod_c[i] <= scale(sel_t, dir_b[i]);
        org_c[i]  <= org_b[i];
      end
    end
  end

  // sums wrap modulo 2^FIX_W
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p_valid <= 1'b0;
      p_x     <= '0;
      p_y     <= '0;
      p_z     <= '0;
    end else begin
      p_valid <= v_c;
      p_x     <= org_c[0] + prod_c[0];
      p_y     <= org_c[1] + prod_c[1];
      p_z     <= org_c[2] + prod_c[2];
    end
  end

endmodule

/* hit_merge.sv */
// joins the range-test result with the computed point into early-miss and hit reports
`timescale 1ns/1ns

module hit_merge (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               rt_valid,
  input  logic               rt_hit,
  input  isect_pkg::fix_t    rt_t,
  input  isect_pkg::tri_id_t rt_tri_id,
  input  isect_pkg::ray_id_t rt_ray_id,
  input  logic               p_valid,
  input  isect_pkg::fix_t    p_x,
  input  isect_pkg::fix_t    p_y,
  input  isect_pkg::fix_t    p_z,
  output logic               miss_valid,
  output isect_pkg::ray_id_t miss_ray_id,
  output logic               hit_valid,
  output isect_pkg::ray_id_t hit_ray_id,
  output isect_pkg::tri_id_t hit_tri_id,
  output isect_pkg::fix_t    hit_t,
  output isect_pkg::fix_t    hit_p_x,
  output isect_pkg::fix_t    hit_p_y,
  output isect_pkg::fix_t    hit_p_z
);

  // hit flag delayed to meet the point
  logic hit_q;

  // early miss, no need to wait for the point
  assign miss_valid  = rt_valid & ~rt_hit;
  assign miss_ray_id = rt_ray_id;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hit_q      <= 1'b0;
      hit_ray_id <= '0;
      hit_tri_id <= '0;
      hit_t      <= '0;
    end else begin
      hit_q      <= rt_valid & rt_hit;
      hit_ray_id <= rt_ray_id;
      hit_tri_id <= rt_tri_id;
      hit_t      <= rt_t;
    end
  end

  assign hit_valid = hit_q & p_valid;

  // point comes straight from p_calc
  assign hit_p_x = p_x;
  assign hit_p_y = p_y;
  assign hit_p_z = p_z;

endmodule

/* isect_stage.sv */
// top of the intersection-decision stage; one ray per cycle in, one miss or hit report out
`timescale 1ns/1ns

module isect_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  isect_pkg::ray_id_t ray_id,
  input  isect_pkg::fix_t    t0,
  input  isect_pkg::fix_t    t1,
  input  logic               tri1_valid,
  input  isect_pkg::tri_id_t tri0_id,
  input  isect_pkg::tri_id_t tri1_id,
  input  isect_pkg::fix_t    t_min,
  input  isect_pkg::fix_t    t_max,
  input  isect_pkg::fix_t    origin_x,
  input  isect_pkg::fix_t    origin_y,
  input  isect_pkg::fix_t    origin_z,
  input  isect_pkg::fix_t    dir_x,
  input  isect_pkg::fix_t    dir_y,
  input  isect_pkg::fix_t    dir_z,
  output logic               miss_valid,
  output isect_pkg::ray_id_t miss_ray_id,
  output logic               hit_valid,
  output isect_pkg::ray_id_t hit_ray_id,
  output isect_pkg::tri_id_t hit_tri_id,
  output isect_pkg::fix_t    hit_t,
  output isect_pkg::fix_t    hit_p_x,
  output isect_pkg::fix_t    hit_p_y,
  output isect_pkg::fix_t    hit_p_z
);

  // selected distance for p_calc
  logic               sel_valid;
  isect_pkg::fix_t    sel_t;

  // range test
  logic               rt_valid;
  logic               rt_hit;
  isect_pkg::fix_t    rt_t;
  isect_pkg::tri_id_t rt_tri_id;
  isect_pkg::ray_id_t rt_ray_id;

  // point
  logic               p_valid;
  isect_pkg::fix_t    p_x;
  isect_pkg::fix_t    p_y;
  isect_pkg::fix_t    p_z;

  t_comp u_t_comp (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .ray_id     (ray_id),
    .t0         (t0),
    .t1         (t1),
    .t_min      (t_min),
    .t_max      (t_max),
    .tri1_valid (tri1_valid),
    .tri0_id    (tri0_id),
    .tri1_id    (tri1_id),
    .sel_valid  (sel_valid),
    .sel_t      (sel_t),
    .sel_tri_id (),
    .sel_ray_id (),
    .rt_valid   (rt_valid),
    .rt_hit     (rt_hit),
    .rt_t       (rt_t),
    .rt_tri_id  (rt_tri_id),
    .rt_ray_id  (rt_ray_id)
  );

  p_calc u_p_calc (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .origin_x  (origin_x),
    .origin_y  (origin_y),
    .origin_z  (origin_z),
    .dir_x     (dir_x),
    .dir_y     (dir_y),
    .dir_z     (dir_z),
    .sel_valid (sel_valid),
    .sel_t     (sel_t),
    .p_valid   (p_valid),
    .p_x       (p_x),
    .p_y       (p_y),
    .p_z       (p_z)
  );

  hit_merge u_hit_merge (
    .clk         (clk),
    .arst_n      (arst_n),
    .rt_valid    (rt_valid),
    .rt_hit      (rt_hit),
    .rt_t        (rt_t),
    .rt_tri_id   (rt_tri_id),
    .rt_ray_id   (rt_ray_id),
    .p_valid     (p_valid),
    .p_x         (p_x),
    .p_y         (p_y),
    .p_z         (p_z),
    .miss_valid  (miss_valid),
    .miss_ray_id (miss_ray_id),
    .hit_valid   (hit_valid),
    .hit_ray_id  (hit_ray_id),
    .hit_tri_id  (hit_tri_id),
    .hit_t       (hit_t),
    .hit_p_x     (hit_p_x),
    .hit_p_y     (hit_p_y),
    .hit_p_z     (hit_p_z)
  );

endmodule

/* tb_isect_stage.sv */
// random-stimulus testbench for isect_stage; a reference model fills expected miss and hit queues
`timescale 1ns/1ns

module tb_isect_stage;

  // expected report for one accepted ray
  typedef struct packed {
    isect_pkg::ray_id_t rid;
    isect_pkg::tri_id_t tid;
    isect_pkg::fix_t    t;
    isect_pkg::fix_t    px;
    isect_pkg::fix_t    py;
    isect_pkg::fix_t    pz;
    logic [31:0]        acc;
  } report_t;

  logic               clk;
  logic               arst_n;
  logic               in_valid;
  isect_pkg::ray_id_t ray_id;
  isect_pkg::fix_t    t0;
  isect_pkg::fix_t    t1;
  logic               tri1_valid;
  isect_pkg::tri_id_t tri0_id;
  isect_pkg::tri_id_t tri1_id;
  isect_pkg::fix_t    t_min;
  isect_pkg::fix_t    t_max;
  isect_pkg::fix_t    origin_x;
  isect_pkg::fix_t    origin_y;
  isect_pkg::fix_t    origin_z;
  isect_pkg::fix_t    dir_x;
  isect_pkg::fix_t    dir_y;
  isect_pkg::fix_t    dir_z;
  logic               miss_valid;
  isect_pkg::ray_id_t miss_ray_id;
  logic               hit_valid;
  isect_pkg::ray_id_t hit_ray_id;
  isect_pkg::tri_id_t hit_tri_id;
  isect_pkg::fix_t    hit_t;
  isect_pkg::fix_t    hit_p_x;
  isect_pkg::fix_t    hit_p_y;
  isect_pkg::fix_t    hit_p_z;

  report_t            miss_q[$];
  report_t            hit_q[$];
  report_t            mon_r;
  isect_pkg::ray_id_t next_tag;
  logic [31:0]        cycle_cnt;
  int                 check_cnt;
  int                 err_cnt;
  int                 timeout_cnt;
  int                 extra_cnt;

  isect_stage u_isect_stage (.*);

  always #4 clk = ~clk;

  // counts rising edges, used for latency
  always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $urandom % n;
  endfunction

  // t*d in Q16.16, wide product then arithmetic shift
  function automatic isect_pkg::fix_t scaled_product(input isect_pkg::fix_t t,
                                                     input isect_pkg::fix_t d);
    longint p;
    p = longint'(t) * longint'(d);
    p = p >>> isect_pkg::FRAC_BITS;
    return p[isect_pkg::FIX_W-1:0];
  endfunction

  // drives one ray on the falling edge and queues what it should produce
  task automatic send_ray(input isect_pkg::fix_t a0, input isect_pkg::fix_t a1, input logic v1,
                          input isect_pkg::fix_t lo, input isect_pkg::fix_t hi);
    report_t         r;
    logic            pick1;
    isect_pkg::fix_t ts;
    @(negedge clk);
    in_valid   = 1'b1;
    ray_id     = next_tag;
    t0         = a0;
    t1         = a1;
    tri1_valid = v1;
    t_min      = lo;
    t_max      = hi;
    tri0_id    = isect_pkg::tri_id_t'($urandom);
    tri1_id    = isect_pkg::tri_id_t'($urandom);
    origin_x   = isect_pkg::fix_t'($urandom);
    origin_y   = isect_pkg::fix_t'($urandom);
    origin_z   = isect_pkg::fix_t'($urandom);
    dir_x      = isect_pkg::fix_t'($urandom);
    dir_y      = isect_pkg::fix_t'($urandom);
    dir_z      = isect_pkg::fix_t'($urandom);
    // triangle 1 only when valid and strictly nearer
    pick1 = v1 && (a1 < a0);
    ts    = pick1 ? a1 : a0;
    r.rid = next_tag;
    r.tid = pick1 ? tri1_id : tri0_id;
    r.t   = ts;
    r.px  = origin_x + scaled_product(ts, dir_x);
    r.py  = origin_y + scaled_product(ts, dir_y);
    r.pz  = origin_z + scaled_product(ts, dir_z);
    r.acc = cycle_cnt + 32'd1;
    if ((lo < ts) && (ts < hi)) hit_q.push_back(r);
    else miss_q.push_back(r);
    next_tag++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    idle(1);
    while ((miss_q.size() != 0 || hit_q.size() != 0) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (miss_q.size() != 0 || hit_q.size() != 0) begin
      timeout_cnt++;
      $display("timeout at %0t: %0d miss and %0d hit reports never arrived",
               $time, miss_q.size(), hit_q.size());
    end
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    if (arst_n && miss_valid) begin
      if (miss_q.size() == 0) begin
        extra_cnt++;
        $display("unexpected miss report for ray %0d at %0t", miss_ray_id, $time);
      end else begin
        mon_r = miss_q.pop_front();
        check("miss_ray_id", 32'(miss_ray_id), 32'(mon_r.rid));
        check("miss latency", cycle_cnt - mon_r.acc, 32'd2);
      end
    end
    if (arst_n && hit_valid) begin
      if (hit_q.size() == 0) begin
        extra_cnt++;
        $display("unexpected hit report for ray %0d at %0t", hit_ray_id, $time);
      end else begin
        mon_r = hit_q.pop_front();
        check("hit_ray_id", 32'(hit_ray_id), 32'(mon_r.rid));
        check("hit_tri_id", 32'(hit_tri_id), 32'(mon_r.tid));
        check("hit_t", hit_t, mon_r.t);
        check("hit_p_x", hit_p_x, mon_r.px);
        check("hit_p_y", hit_p_y, mon_r.py);
        check("hit_p_z", hit_p_z, mon_r.pz);
        check("hit latency", cycle_cnt - mon_r.acc, 32'd3);
      end
    end
  end

  initial begin
    isect_pkg::fix_t lo;
    isect_pkg::fix_t hi;
    isect_pkg::fix_t a0;
    isect_pkg::fix_t a1;
    void'($urandom(72));
    clk = 1'b0;
    arst_n = 1'b0;
    in_valid = 1'b0;
    ray_id = '0;
    t0 = '0;
    t1 = '0;
    tri1_valid = 1'b0;
    tri0_id = '0;
    tri1_id = '0;
    t_min = '0;
    t_max = '0;
    origin_x = '0;
    origin_y = '0;
    origin_z = '0;
    dir_x = '0;
    dir_y = '0;
    dir_z = '0;
    next_tag = '0;
    cycle_cnt = '0;
    check_cnt = 0;
    err_cnt = 0;
    timeout_cnt = 0;
    extra_cnt = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // quiet after reset
    repeat (8) begin
      @(negedge clk);
      check("miss_valid idle", 32'(miss_valid), 32'd0);
      check("hit_valid idle", 32'(hit_valid), 32'd0);
    end

    // selection, wide interval so every ray hits; some ties
    repeat (60) begin
      a0 = isect_pkg::fix_t'(rand_below(32'h0100_0000));
      a1 = (rand_below(6) == 0) ? a0 : isect_pkg::fix_t'(rand_below(32'h0100_0000));
      send_ray(a0, a1, rand_below(2) == 1, -32'sh0001_0000, 32'sh7fff_ffff);
      idle(int'(rand_below(3)));
    end
    wait_drained(40);

    // range test at and around both bounds, one ray at a time
    repeat (20) begin
      lo = isect_pkg::fix_t'(rand_below(32'h0020_0000)) - 32'sh0010_0000;
      hi = lo + 32'sd2 + isect_pkg::fix_t'(rand_below(32'h0010_0000));
      send_ray(lo - 32'sd1 - isect_pkg::fix_t'(rand_below(1000)), '0, 1'b0, lo, hi);
      idle(3);
      send_ray(lo, '0, 1'b0, lo, hi);
      idle(3);
      send_ray(lo + 32'sd1 + isect_pkg::fix_t'(rand_below(hi - lo - 1)), '0, 1'b0, lo, hi);
      idle(4);
      send_ray(hi, '0, 1'b0, lo, hi);
      idle(3);
      send_ray(hi + 32'sd1 + isect_pkg::fix_t'(rand_below(1000)), '0, 1'b0, lo, hi);
      idle(3);
    end
    wait_drained(40);

    // full-range distances so products and sums wrap
    repeat (40) begin
      send_ray(isect_pkg::fix_t'($urandom), isect_pkg::fix_t'($urandom), rand_below(2) == 1,
               32'sh8000_0000, 32'sh7fff_ffff);
      idle(int'(rand_below(2)));
    end
    wait_drained(40);

    // back-to-back burst, hits and misses mixed
    repeat (40) begin
      a0 = isect_pkg::fix_t'(rand_below(32'h0018_0000)) - 32'sh0008_0000;
      a1 = isect_pkg::fix_t'(rand_below(32'h0018_0000)) - 32'sh0008_0000;
      send_ray(a0, a1, rand_below(2) == 1, '0, 32'sh0008_0000);
    end
    wait_drained(50);
    idle(4);

    $display("checks %0d, mismatches %0d, timeouts %0d, unexpected reports %0d",
             check_cnt, err_cnt, timeout_cnt, extra_cnt);
    if (err_cnt + timeout_cnt + extra_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* files.f */
isect_pkg.sv
t_comp.sv
p_calc.sv
hit_merge.sv
isect_stage.sv
tb_isect_stage.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_isect_stage
FILELIST   := files.f
FLAGS      := --binary --timing -Wno-fatal -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG   := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf obj_dir
